// File: design/mm_cfg.svh
// ############################
// matrix accelerator sizes
// dimension, element, sum and address widths
// ############################

`ifndef MM_CFG_SVH
`define MM_CFG_SVH

// square matrix dimension
`define MM_N 4

// unsigned element of A and B
`define MM_ELEM_W 8

// one element of C
`define MM_SUM_W 32

// byte address on the memory side
`define MM_ADDR_W 32

`endif

// File: design/mem_bus_pkg.sv
// ############################
// memory bus types
// read request, tagged read beat, write beat
// ############################

`default_nettype none

`include "mm_cfg.svh"

package mem_bus_pkg;

    // read tag, one per matrix
    typedef enum logic {
        RD_ID_A = 1'b0,
        RD_ID_B = 1'b1
    } rd_id_e;

    // always a burst of MM_N beats, beat k at addr + 4k
    typedef struct packed {
        logic [`MM_ADDR_W-1:0] addr;
        rd_id_e                id;
    } rd_req_t;

    // one row per beat, element j in byte j
    typedef struct packed {
        logic [`MM_N*`MM_ELEM_W-1:0] data;
        rd_id_e                      id;
        logic                        last;
    } rd_rsp_t;

    // one row of C, element j at bit 32j
    typedef struct packed {
        logic [`MM_ADDR_W-1:0]      addr;
        logic [`MM_N*`MM_SUM_W-1:0] data;
        logic                       last;
    } wr_beat_t;

endpackage

`default_nettype wire

// File: design/mm_types_pkg.sv
// ############################
// matrix and FSM types
// ############################

`default_nettype none

`include "mm_cfg.svh"

package mm_types_pkg;

    // one row of A or B
    typedef logic [`MM_N-1:0][`MM_ELEM_W-1:0] mat_row_t;

    // row i at index i
    typedef mat_row_t [`MM_N-1:0] mat_t;

    // one row of C
    typedef logic [`MM_N-1:0][`MM_SUM_W-1:0] c_row_t;

    typedef enum logic [1:0] {
        CTRL_IDLE = 2'd0,
        CTRL_LOAD = 2'd1,
        CTRL_CALC = 2'd2
    } ctrl_state_e;

    typedef enum logic {
        ENG_IDLE = 1'b0,
        ENG_SEND = 1'b1
    } eng_state_e;

endpackage

`default_nettype wire

// File: design/mat_loader.sv
// ############################
// matrix loader
// one tagged read burst into a row register file
// ############################

`timescale 1ns/100ps
`default_nettype none

`include "mm_cfg.svh"

module mat_loader
    import mem_bus_pkg::*;
    import mm_types_pkg::*;
#(
    parameter rd_id_e LOADER_ID = RD_ID_A
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  load_start_i,
    input  wire logic [`MM_ADDR_W-1:0] base_addr_i,
    output rd_req_t                    req_o,
    output logic                       req_valid_o,
    input  wire logic                  req_grant_i,
    input  wire rd_rsp_t               rsp_i,
    input  wire logic                  rsp_fire_i,
    output mat_t                       mat_o,
    output logic                       loaded_o
);

    localparam int ROW_W = $clog2(`MM_N);

    logic             req_valid_q;
    logic             loaded_q;
    logic [ROW_W-1:0] row_cnt_q;
    logic             beat_mine;
    mat_t             mat_q;

    // only beats carrying our own tag
    assign beat_mine = rsp_fire_i && (rsp_i.id == LOADER_ID);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_valid_q <= 1'b0;
            loaded_q    <= 1'b0;
            row_cnt_q   <= '0;
        end else if (load_start_i) begin
            req_valid_q <= 1'b1;
            loaded_q    <= 1'b0;
            row_cnt_q   <= '0;
        end else begin
            // request held until the arbiter reports acceptance
            if (req_grant_i) begin
                req_valid_q <= 1'b0;
            end
            if (beat_mine) begin
                row_cnt_q <= row_cnt_q + ROW_W'(1);
                if (rsp_i.last) begin
                    loaded_q <= 1'b1;
                end
            end
        end
    end

    // rows land in arrival order
    always_ff @(posedge clk) begin
        if (beat_mine) begin
            mat_q[row_cnt_q] <= rsp_i.data;
        end
    end

    assign req_o.addr  = base_addr_i;
    assign req_o.id    = LOADER_ID;
    assign req_valid_o = req_valid_q;
    assign mat_o       = mat_q;
    assign loaded_o    = loaded_q;

endmodule

`default_nettype wire

// File: design/mm_engine.sv
// ############################
// multiply engine
// C = A x B, one row of C per write beat
// ############################

`timescale 1ns/100ps
`default_nettype none

`include "mm_cfg.svh"

module mm_engine
    import mem_bus_pkg::*;
    import mm_types_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  calc_start_i,
    input  wire mat_t                  mat_a_i,
    input  wire mat_t                  mat_b_i,
    input  wire logic [`MM_ADDR_W-1:0] c_base_i,
    output wr_beat_t                   wr_beat_o,
    output logic                       wr_valid_o,
    input  wire logic                  wr_ready_i,
    output logic                       calc_done_o
);

    localparam int ROW_W     = $clog2(`MM_N);
    localparam int ROW_BYTES = `MM_N * `MM_SUM_W / 8;

    eng_state_e       state_q;
    logic [ROW_W-1:0] row_q;
    wr_beat_t         beat_q;
    wr_beat_t         next_beat;
    logic             beat_fire;
    logic             load_beat;

    // dot products of one A row with every B column
    function automatic c_row_t row_product(input mat_row_t a_row, input mat_t b);
        c_row_t acc;
        acc = '0;
        for (int j = 0; j < `MM_N; j++) begin
            for (int k = 0; k < `MM_N; k++) begin
                acc[j] = acc[j] + `MM_SUM_W'(a_row[k]) * `MM_SUM_W'(b[k][j]);
            end
        end
        return acc;
    endfunction

    // row_q points at the next row to register
    always_comb begin
        next_beat.addr = c_base_i + `MM_ADDR_W'(row_q) * `MM_ADDR_W'(ROW_BYTES);
        next_beat.data = row_product(mat_a_i[row_q], mat_b_i);
        next_beat.last = (row_q == ROW_W'(`MM_N - 1));
    end

    assign beat_fire = wr_valid_o && wr_ready_i;
    assign load_beat = ((state_q == ENG_IDLE) && calc_start_i)
                    || ((state_q == ENG_SEND) && beat_fire && !beat_q.last);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ENG_IDLE;
            row_q   <= '0;
        end else begin
            case (state_q)
                ENG_IDLE: if (calc_start_i) state_q <= ENG_SEND;
                ENG_SEND: if (beat_fire && beat_q.last) state_q <= ENG_IDLE;
                default:  state_q <= ENG_IDLE;
            endcase
            // wraps back to row 0 after the last one
            if (load_beat) begin
                row_q <= row_q + ROW_W'(1);
            end
        end
    end

    // beat holds under back-pressure
    always_ff @(posedge clk) begin
        if (load_beat) begin
            beat_q <= next_beat;
        end
    end

    assign wr_beat_o   = beat_q;
    assign wr_valid_o  = (state_q == ENG_SEND);
    assign calc_done_o = beat_fire && beat_q.last;

endmodule

`default_nettype wire

// File: design/dma_ctrl.sv
// ############################
// DMA controller
// job FSM, read-request arbiter, start/done pulses
// ############################

`timescale 1ns/100ps
`default_nettype none

module dma_ctrl
    import mem_bus_pkg::*;
    import mm_types_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    start_i,
    input  wire rd_req_t req_a_i,
    input  wire logic    req_a_valid_i,
    input  wire rd_req_t req_b_i,
    input  wire logic    req_b_valid_i,
    output logic         grant_a_o,
    output logic         grant_b_o,
    output rd_req_t      rd_req_o,
    output logic         rd_req_valid_o,
    input  wire logic    rd_req_ready_i,
    output logic         rd_rsp_ready_o,
    input  wire logic    loaded_a_i,
    input  wire logic    loaded_b_i,
    output logic         load_start_o,
    output logic         calc_start_o,
    input  wire logic    calc_done_i,
    output logic         done_o
);

    ctrl_state_e state_q;
    logic        load_start_q;
    logic        calc_start_q;
    logic        done_q;
    logic        hold_q;
    rd_id_e      sel_q;
    rd_id_e      sel;
    logic        req_fire;

    // A first; a stalled offer keeps its owner
    always_comb begin
        if (hold_q) begin
            sel = sel_q;
        end else if (req_a_valid_i) begin
            sel = RD_ID_A;
        end else begin
            sel = RD_ID_B;
        end
    end

    assign rd_req_o       = (sel == RD_ID_A) ? req_a_i : req_b_i;
    assign rd_req_valid_o = (sel == RD_ID_A) ? req_a_valid_i : req_b_valid_i;
    assign req_fire       = rd_req_valid_o && rd_req_ready_i;
    assign grant_a_o      = req_fire && (sel == RD_ID_A);
    assign grant_b_o      = req_fire && (sel == RD_ID_B);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q <= 1'b0;
            sel_q  <= RD_ID_A;
        end else begin
            hold_q <= rd_req_valid_o && !rd_req_ready_i;
            sel_q  <= sel;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q      <= CTRL_IDLE;
            load_start_q <= 1'b0;
            calc_start_q <= 1'b0;
            done_q       <= 1'b0;
        end else begin
            load_start_q <= 1'b0;
            calc_start_q <= 1'b0;
            done_q       <= 1'b0;
            case (state_q)
                CTRL_IDLE: begin
                    if (start_i) begin
                        state_q      <= CTRL_LOAD;
                        load_start_q <= 1'b1;
                    end
                end
                CTRL_LOAD: begin
                    // loaded flags still show the previous job during load_start
                    if (loaded_a_i && loaded_b_i && !load_start_q) begin
                        state_q      <= CTRL_CALC;
                        calc_start_q <= 1'b1;
                    end
                end
                CTRL_CALC: begin
                    if (calc_done_i) begin
                        state_q <= CTRL_IDLE;
                        done_q  <= 1'b1;
                    end
                end
                default: state_q <= CTRL_IDLE;
            endcase
        end
    end

    assign rd_rsp_ready_o = (state_q == CTRL_LOAD);
    assign load_start_o   = load_start_q;
    assign calc_start_o   = calc_start_q;
    assign done_o         = done_q;

endmodule

`default_nettype wire

// File: design/mm_accel_top.sv
// ############################
// matrix multiply accelerator top
// controller, two loaders and engine
// ############################

`timescale 1ns/100ps
`default_nettype none

`include "mm_cfg.svh"

module mm_accel_top
    import mem_bus_pkg::*;
    import mm_types_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic [`MM_ADDR_W-1:0] mat_a_addr_i,
    input  wire logic [`MM_ADDR_W-1:0] mat_b_addr_i,
    input  wire logic [`MM_ADDR_W-1:0] mat_c_addr_i,
    input  wire logic                  start_i,
    output logic                       done_o,
    output rd_req_t                    rd_req_o,
    output logic                       rd_req_valid_o,
    input  wire logic                  rd_req_ready_i,
    input  wire rd_rsp_t               rd_rsp_i,
    input  wire logic                  rd_rsp_valid_i,
    output logic                       rd_rsp_ready_o,
    output wr_beat_t                   wr_beat_o,
    output logic                       wr_valid_o,
    input  wire logic                  wr_ready_i
);

    rd_req_t req_a, req_b;
    logic    req_a_valid, req_b_valid;
    logic    grant_a, grant_b;
    logic    loaded_a, loaded_b;
    logic    load_start, calc_start, calc_done;
    logic    rsp_fire;
    mat_t    mat_a, mat_b;

    assign rsp_fire = rd_rsp_valid_i && rd_rsp_ready_o;

    dma_ctrl u_ctrl (
        .clk, .rst_n, .start_i,
        .req_a_i(req_a), .req_a_valid_i(req_a_valid),
        .req_b_i(req_b), .req_b_valid_i(req_b_valid),
        .grant_a_o(grant_a), .grant_b_o(grant_b),
        .rd_req_o, .rd_req_valid_o, .rd_req_ready_i, .rd_rsp_ready_o,
        .loaded_a_i(loaded_a), .loaded_b_i(loaded_b),
        .load_start_o(load_start), .calc_start_o(calc_start),
        .calc_done_i(calc_done), .done_o
    );

    mat_loader #(.LOADER_ID(RD_ID_A)) loader_a (
        .clk, .rst_n, .load_start_i(load_start), .base_addr_i(mat_a_addr_i),
        .req_o(req_a), .req_valid_o(req_a_valid), .req_grant_i(grant_a),
        .rsp_i(rd_rsp_i), .rsp_fire_i(rsp_fire), .mat_o(mat_a), .loaded_o(loaded_a)
    );

    mat_loader #(.LOADER_ID(RD_ID_B)) loader_b (
        .clk, .rst_n, .load_start_i(load_start), .base_addr_i(mat_b_addr_i),
        .req_o(req_b), .req_valid_o(req_b_valid), .req_grant_i(grant_b),
        .rsp_i(rd_rsp_i), .rsp_fire_i(rsp_fire), .mat_o(mat_b), .loaded_o(loaded_b)
    );

    mm_engine u_engine (
        .clk, .rst_n, .calc_start_i(calc_start),
        .mat_a_i(mat_a), .mat_b_i(mat_b), .c_base_i(mat_c_addr_i),
        .wr_beat_o, .wr_valid_o, .wr_ready_i, .calc_done_o(calc_done)
    );

endmodule

`default_nettype wire

// File: verification/mm_accel_props.sv
// ############################
// accelerator handshake assertions
// bound into the top level
// ############################

`timescale 1ns/100ps
`default_nettype none

module mm_accel_props
    import mem_bus_pkg::*;
(
    input wire logic     clk,
    input wire logic     rst_n,
    input wire rd_req_t  rd_req_o,
    input wire logic     rd_req_valid_o,
    input wire logic     rd_req_ready_i,
    input wire logic     rd_rsp_ready_o,
    input wire logic     loaded_a,
    input wire logic     loaded_b,
    input wire wr_beat_t wr_beat_o,
    input wire logic     wr_valid_o,
    input wire logic     wr_ready_i,
    input wire logic     done_o
);

    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rd_req_valid_o && !rd_req_ready_i |=> rd_req_valid_o && $stable(rd_req_o))
        else $error("read request dropped or changed while stalled");

    // ready stays up until both matrices are in
    rsp_ready_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rd_rsp_ready_o && !(loaded_a && loaded_b) |=> rd_rsp_ready_o)
        else $error("response ready fell before both matrices were loaded");

    wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wr_valid_o && !wr_ready_i |=> wr_valid_o && $stable(wr_beat_o))
        else $error("write beat dropped or changed while stalled");

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |=> !done_o)
        else $error("done held longer than one cycle");

    // response ready marks the load phase
    no_write_in_load: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr_valid_o && rd_rsp_ready_o))
        else $error("write beat valid while matrices are loading");

endmodule

bind mm_accel_top mm_accel_props props_i (
    .clk, .rst_n, .rd_req_o, .rd_req_valid_o, .rd_req_ready_i, .rd_rsp_ready_o,
    .loaded_a, .loaded_b, .wr_beat_o, .wr_valid_o, .wr_ready_i, .done_o
);

`default_nettype wire

// File: verification/mm_accel_tb.sv
// ############################
// matrix accelerator testbench
// random jobs against a memory model
// and a reference multiply
// ############################

`timescale 1ns/100ps
`default_nettype none

`include "mm_cfg.svh"

module mm_accel_tb
    import mem_bus_pkg::*;
    import mm_types_pkg::*;
();

    localparam int NUM_JOBS   = 20;
    localparam int CLK_PERIOD = 10;
    localparam int TIMEOUT_NS = (NUM_JOBS * 400 + 10) * CLK_PERIOD;

    logic                  clk;
    logic                  rst_n;
    logic [`MM_ADDR_W-1:0] mat_a_addr_i;
    logic [`MM_ADDR_W-1:0] mat_b_addr_i;
    logic [`MM_ADDR_W-1:0] mat_c_addr_i;
    logic                  start_i;
    logic                  done_o;
    rd_req_t               rd_req_o;
    logic                  rd_req_valid_o;
    logic                  rd_req_ready_i;
    rd_rsp_t               rd_rsp_i;
    logic                  rd_rsp_valid_i;
    logic                  rd_rsp_ready_o;
    wr_beat_t              wr_beat_o;
    logic                  wr_valid_o;
    logic                  wr_ready_i;

    logic [31:0] lfsr_q = 32'hd2e0a194;
    // sparse word memory keyed by byte address
    logic [31:0] mem [logic [31:0]];
    // beats of accepted bursts per read tag
    rd_rsp_t     beats_a[$];
    rd_rsp_t     beats_b[$];
    rd_req_t     exp_req [2*NUM_JOBS];
    wr_beat_t    exp_wr [`MM_N*NUM_JOBS];
    int          job_idx      = 0;
    int          req_cnt      = 0;
    int          wr_cnt       = 0;
    int          done_cnt     = 0;
    int          rsp_fire_cnt = 0;
    int          rsp_seen     = 0;

    mm_accel_top dut_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "run stopped");
    endtask

    task automatic check_req(input string name, input rd_req_t exp_v, input rd_req_t act);
        if (act !== exp_v) begin
            fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp_v, act));
        end
    endtask

    task automatic check_wr(input string name, input wr_beat_t exp_v, input wr_beat_t act);
        if (act !== exp_v) begin
            fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp_v, act));
        end
    endtask

    // random matrices, addresses and the expected traffic of one job
    task automatic prepare_job(input int job);
        logic [31:0] r;
        mat_t        mat_a;
        mat_t        mat_b;
        c_row_t      c_row;
        wr_beat_t    beat;
        rd_req_t     req;
        r = rand_bits(20);
        mat_a_addr_i = {4'h1, r[19:0], 8'h00};
        r = rand_bits(20);
        mat_b_addr_i = {4'h2, r[19:0], 8'h00};
        r = rand_bits(20);
        mat_c_addr_i = {4'h3, r[19:0], 8'h00};
        for (int i = 0; i < `MM_N; i++) begin
            for (int j = 0; j < `MM_N; j++) begin
                r = rand_bits(8);
                mat_a[i][j] = r[7:0];
                r = rand_bits(8);
                mat_b[i][j] = r[7:0];
            end
            mem[mat_a_addr_i + `MM_ADDR_W'(4 * i)] = mat_a[i];
            mem[mat_b_addr_i + `MM_ADDR_W'(4 * i)] = mat_b[i];
        end
        req.addr = mat_a_addr_i;
        req.id   = RD_ID_A;
        exp_req[2*job] = req;
        req.addr = mat_b_addr_i;
        req.id   = RD_ID_B;
        exp_req[2*job+1] = req;
        // C[i][j] = sum over k of A[i][k] * B[k][j]
        for (int i = 0; i < `MM_N; i++) begin
            for (int j = 0; j < `MM_N; j++) begin
                c_row[j] = '0;
                for (int k = 0; k < `MM_N; k++) begin
                    c_row[j] = c_row[j] + `MM_SUM_W'(mat_a[i][k]) * `MM_SUM_W'(mat_b[k][j]);
                end
            end
            beat.addr = mat_c_addr_i + `MM_ADDR_W'(16 * i);
            beat.data = c_row;
            beat.last = (i == `MM_N - 1);
            exp_wr[`MM_N*job+i] = beat;
        end
        job_idx = job;
    endtask

    // random ready lines and interleaved response beats with gaps
    task automatic drive_memory();
        logic [31:0] r;
        r              = rand_bits(1);
        rd_req_ready_i = r[0];
        r              = rand_bits(1);
        wr_ready_i     = r[0];
        // a beat on offer stays until it transfers
        if (!(rd_rsp_valid_i && rsp_fire_cnt == rsp_seen)) begin
            rsp_seen       = rsp_fire_cnt;
            r              = rand_bits(2);
            rd_rsp_valid_i = 1'b0;
            if (r[0] && beats_a.size() > 0) begin
                rd_rsp_i       = beats_a[0];
                rd_rsp_valid_i = 1'b1;
            end else if (r[1] && beats_b.size() > 0) begin
                rd_rsp_i       = beats_b[0];
                rd_rsp_valid_i = 1'b1;
            end
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        drive_memory();
    endtask

    task automatic accept_request();
        rd_rsp_t beat;
        if (req_cnt >= 2 * (job_idx + 1)) begin
            fail_run($sformatf("extra read request during job %0d", job_idx));
        end else begin
            check_req($sformatf("requests job %0d request %0d", job_idx, req_cnt % 2),
                      exp_req[req_cnt], rd_req_o);
            for (int k = 0; k < `MM_N; k++) begin
                beat.data = mem[rd_req_o.addr + `MM_ADDR_W'(4 * k)];
                beat.id   = rd_req_o.id;
                beat.last = (k == `MM_N - 1);
                if (beat.id == RD_ID_A) begin
                    beats_a.push_back(beat);
                end else begin
                    beats_b.push_back(beat);
                end
            end
            req_cnt++;
        end
    endtask

    task automatic take_write();
        if (wr_cnt >= `MM_N * (job_idx + 1)) begin
            fail_run($sformatf("extra write beat during job %0d", job_idx));
        end else begin
            check_wr($sformatf("multiply job %0d row %0d", job_idx, wr_cnt % `MM_N),
                     exp_wr[wr_cnt], wr_beat_o);
            wr_cnt++;
        end
    endtask

    // outputs read here are still the values from before the edge
    always @(posedge clk) begin
        if (rst_n) begin
            // done must follow the last write, not come with it
            if (done_o) begin
                if (wr_cnt != `MM_N * (done_cnt + 1) || req_cnt != 2 * (done_cnt + 1)) begin
                    fail_run("done pulse without exactly one finished job behind it");
                end else begin
                    done_cnt++;
                end
            end
            if (rd_req_valid_o && rd_req_ready_i) begin
                accept_request();
            end
            if (rd_rsp_valid_i && rd_rsp_ready_o) begin
                rsp_fire_cnt++;
                if (rd_rsp_i.id == RD_ID_A) begin
                    void'(beats_a.pop_front());
                end else begin
                    void'(beats_b.pop_front());
                end
            end
            if (wr_valid_o && wr_ready_i) begin
                take_write();
            end
        end
    end

    initial begin
        logic [31:0] r;
        clk            = 1'b0;
        rst_n          = 1'b0;
        start_i        = 1'b0;
        mat_a_addr_i   = '0;
        mat_b_addr_i   = '0;
        mat_c_addr_i   = '0;
        rd_req_ready_i = 1'b0;
        rd_rsp_i       = '0;
        rd_rsp_valid_i = 1'b0;
        wr_ready_i     = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        for (int job = 0; job < NUM_JOBS; job++) begin
            prepare_job(job);
            start_i = 1'b1;
            while (done_cnt == job) begin
                next_cycle();
                // extra starts only while the last row is still pending
                r       = rand_bits(3);
                start_i = (wr_cnt < `MM_N * (job + 1)) && (r[2:0] == 3'd0);
            end
            repeat (2) begin
                next_cycle();
                start_i = 1'b0;
            end
        end
        if (done_cnt != NUM_JOBS || wr_cnt != `MM_N * NUM_JOBS || req_cnt != 2 * NUM_JOBS) begin
            fail_run("job, request or write count is off at the end of the run");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

    // 400 cycles per job
    initial begin
        #(TIMEOUT_NS);
        fail_run($sformatf("timeout: job %0d did not finish in time", job_idx));
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+design
design/mem_bus_pkg.sv
design/mm_types_pkg.sv
design/mat_loader.sv
design/mm_engine.sv
design/dma_ctrl.sv
design/mm_accel_top.sv
verification/mm_accel_props.sv
verification/mm_accel_tb.sv

// File: Makefile
SIM := obj_dir/Vmm_accel_tb

.PHONY: run clean

run: $(SIM)
	./$(SIM)

$(SIM): sim.f $(wildcard design/*.sv design/*.svh verification/*.sv)
	verilator --binary --timing --assert -j 0 --top-module mm_accel_tb -f sim.f

clean:
	rm -rf obj_dir
